// ==== verilog.f ====
+incdir+verification
hdl/rv32i_pkg.sv
hdl/decoder.sv
hdl/regfile.sv
hdl/alu.sv
hdl/execute_stage.sv
hdl/rv32i_core.sv
verification/rv32i_core_sva.sv
verification/tb_rv32i_core.sv

// ==== verification/rv32i_ref_model.svh ====
`ifndef RV32I_REF_MODEL_SVH
`define RV32I_REF_MODEL_SVH

// Expected store trace, in program order
logic [31:0] exp_addr[$];
logic [31:0] exp_data[$];

// Number of loads the program executes
int exp_loads;

function automatic logic [31:0] compute_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
  logic [31:0] r;
  case (f3)
    3'd0: r = alt ? a - b : a + b;
    3'd1: r = a << b[4:0];
    3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3: r = (a < b) ? 32'd1 : 32'd0;
    3'd4: r = a ^ b;
    3'd5: begin
      if (alt) r = $unsigned($signed(a) >>> b[4:0]);
      else r = a >> b[4:0];
    end
    3'd6: r = a | b;
    default: r = a & b;
  endcase
  return r;
endfunction

// Runs the program in imem one instruction at a time until the jal-to-self
task automatic run_model(output bit done);
  logic [31:0] x [32];
  logic [31:0] mem [64];
  logic [31:0] pc, npc, ins, a, b, res, ea;
  logic [31:0] imm_i, imm_s, imm_b, imm_j;
  logic [2:0]  f3;
  logic        wr, taken;
  int          steps;
  for (int i = 0; i < 32; i++) x[i] = '0;
  for (int i = 0; i < 64; i++) mem[i] = data_fill(i);
  exp_addr.delete();
  exp_data.delete();
  exp_loads = 0;
  pc = reset_pc;
  done = 0;
  steps = 0;
  while (!done && steps < 2000) begin
    ins = imem[pc[9:2]];
    steps++;
    if (ins == self_loop) begin
      done = 1;
    end else begin
      a = x[ins[19:15]];
      b = x[ins[24:20]];
      f3 = ins[14:12];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      npc = pc + 4;
      wr = 1;
      res = '0;
      case (ins[6:0])
        7'h33: res = compute_alu(f3, ins[30], a, b);
        7'h13: res = compute_alu(f3, f3 == 3'd5 && ins[30], a, imm_i);
        7'h37: res = {ins[31:12], 12'b0};
        7'h17: res = pc + {ins[31:12], 12'b0};
        7'h6f: begin
          res = pc + 4;
          npc = pc + imm_j;
        end
        7'h67: begin
          res = pc + 4;
          npc = (a + imm_i) & ~32'd1;
        end
        7'h63: begin
          wr = 0;
          case (f3)
            3'd0: taken = a == b;
            3'd1: taken = a != b;
            3'd4: taken = $signed(a) < $signed(b);
            3'd5: taken = $signed(a) >= $signed(b);
            3'd6: taken = a < b;
            default: taken = a >= b;
          endcase
          if (taken) npc = pc + imm_b;
        end
        7'h03: begin
          ea = a + imm_i;
          res = mem[ea[7:2]];
          exp_loads++;
        end
        7'h23: begin
          wr = 0;
          ea = a + imm_s;
          mem[ea[7:2]] = b;
          exp_addr.push_back(ea);
          exp_data.push_back(b);
        end
        default: wr = 0;
      endcase
      if (wr && ins[11:7] != 5'd0) x[ins[11:7]] = res;
      pc = npc;
    end
  end
endtask

`endif

// ==== verification/tb_rv32i_core.sv ====
`timescale 1ns/10ps

module tb_rv32i_core import rv32i_pkg::*; ();

  localparam logic [31:0] reset_pc  = 32'h0000_0100;
  localparam logic [31:0] self_loop = 32'h0000_006f;
  localparam int          timeout   = 3000;

  logic        clk = 1'b0;
  logic        rst = 1'b0;
  logic [31:0] instr_addr, instr_rdata, data_addr, data_wdata, data_rdata;
  logic        data_we, data_re;
  logic [31:0] imem [256];
  logic [31:0] dmem [64];
  logic [31:0] prog [$];
  logic [31:0] obs_addr [$];
  logic [31:0] obs_data [$];
  logic [31:0] end_addr;
  int          end_hits, errors, programs, stores_checked;
  int          obs_loads;

  function automatic logic [31:0] data_fill(input int i);
    return (i + 1) * 32'h9e37_79b1;
  endfunction

  `include "rv32i_ref_model.svh"

  always #5 clk = ~clk;

  rv32i_core #(.RESET_PC(reset_pc)) rv32i_core_inst (
    .clk         (clk),
    .rst         (rst),
    .instr_addr  (instr_addr),
    .instr_rdata (instr_rdata),
    .data_addr   (data_addr),
    .data_wdata  (data_wdata),
    .data_we     (data_we),
    .data_re     (data_re),
    .data_rdata  (data_rdata)
  );

  // Combinational memories, data written on the clock edge
  assign instr_rdata = imem[instr_addr[9:2]];
  assign data_rdata  = dmem[data_addr[7:2]];

  always @(posedge clk) begin
    if (!rst && data_we) dmem[data_addr[7:2]] <= data_wdata;
  end

  always @(negedge clk) begin
    if (rst && (data_we || data_re)) begin
      errors++;
      $display("Data port active during reset");
    end
    if (!rst && data_we) begin
      obs_addr.push_back(data_addr);
      obs_data.push_back(data_wdata);
    end
    if (!rst && data_re) obs_loads++;
    if (!rst && instr_addr == end_addr) end_hits++;
  end

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  function automatic logic [31:0] here();
    return reset_pc + 4 * prog.size();
  endfunction

  // Dump x1 to x7 to memory and park in a self-loop
  task automatic finish_program();
    for (int r = 1; r < 8; r++) prog.push_back(s_type(12'(128 + 4 * r), 5'(r), 5'd0));
    prog.push_back(self_loop);
  endtask

  task automatic build_arith();
    prog.delete();
    prog.push_back(i_type(12'd5, 5'd0, 3'd0, 5'd1, 7'h13));
    prog.push_back(i_type(-12'sd3, 5'd1, 3'd0, 5'd2, 7'h13));
    prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
    prog.push_back(r_type(7'h20, 5'd1, 5'd3, 3'd0, 5'd4));
    prog.push_back({20'h12345, 5'd5, 7'h37});
    prog.push_back(i_type(12'h678, 5'd5, 3'd0, 5'd5, 7'h13));
    prog.push_back({20'h00001, 5'd6, 7'h17});
    prog.push_back(r_type(7'h00, 5'd6, 5'd5, 3'd4, 5'd7));
    prog.push_back(r_type(7'h00, 5'd2, 5'd7, 3'd1, 5'd1));
    prog.push_back(i_type({7'h20, 5'd3}, 5'd1, 3'd5, 5'd2, 7'h13));
    prog.push_back(r_type(7'h00, 5'd4, 5'd1, 3'd3, 5'd3));
    finish_program();
  endtask

  task automatic build_load_store();
    prog.delete();
    prog.push_back(i_type(12'd77, 5'd0, 3'd0, 5'd1, 7'h13));
    prog.push_back({20'habcde, 5'd2, 7'h37});
    prog.push_back(s_type(12'd8, 5'd1, 5'd0));
    prog.push_back(s_type(12'd12, 5'd2, 5'd0));
    prog.push_back(i_type(12'd8, 5'd0, 3'd2, 5'd3, 7'h03));
    prog.push_back(r_type(7'h00, 5'd3, 5'd3, 3'd0, 5'd4));
    prog.push_back(i_type(12'd12, 5'd0, 3'd2, 5'd5, 7'h03));
    prog.push_back(r_type(7'h00, 5'd4, 5'd5, 3'd4, 5'd6));
    prog.push_back(i_type(12'd200, 5'd0, 3'd2, 5'd7, 7'h03));
    finish_program();
  endtask

  // Each condition once taken and once not taken, then JAL and JALR
  task automatic build_branch_jump();
    logic [2:0] f3s [12] = '{0, 0, 1, 1, 4, 4, 5, 5, 6, 6, 7, 7};
    logic [4:0] rs1s [12] = '{1, 1, 1, 1, 1, 2, 2, 1, 2, 1, 1, 2};
    logic [4:0] rs2s [12] = '{3, 2, 2, 3, 2, 1, 1, 2, 1, 2, 2, 1};
    logic [31:0] t;
    prog.delete();
    prog.push_back(i_type(-12'sd5, 5'd0, 3'd0, 5'd1, 7'h13));
    prog.push_back(i_type(12'd3, 5'd0, 3'd0, 5'd2, 7'h13));
    prog.push_back(i_type(-12'sd5, 5'd0, 3'd0, 5'd3, 7'h13));
    prog.push_back(i_type(12'd1, 5'd0, 3'd0, 5'd4, 7'h13));
    for (int i = 0; i < 12; i++) begin
      prog.push_back(b_type(13'd12, rs2s[i], rs1s[i], f3s[i]));
      prog.push_back(s_type(12'd240, 5'd4, 5'd0));
      prog.push_back(s_type(12'd244, 5'd4, 5'd0));
      prog.push_back(i_type(12'd1, 5'd4, 3'd0, 5'd4, 7'h13));
      prog.push_back(s_type(12'd248, 5'd4, 5'd0));
    end
    prog.push_back(j_type(21'd12, 5'd5));
    prog.push_back(s_type(12'd240, 5'd4, 5'd0));
    prog.push_back(s_type(12'd244, 5'd4, 5'd0));
    t = here() + 12;
    prog.push_back(i_type(t[11:0], 5'd0, 3'd0, 5'd6, 7'h67));
    prog.push_back(s_type(12'd240, 5'd4, 5'd0));
    prog.push_back(s_type(12'd244, 5'd4, 5'd0));
    finish_program();
  endtask

  task automatic build_random();
    int n, t, kind, idx;
    logic [4:0] rd, rs1, rs2;
    logic [2:0] f3;
    logic [31:0] tgt;
    prog.delete();
    n = 16 + $urandom % 12;
    for (int i = 0; i < n; i++) begin
      kind = $urandom % 10;
      rd = 5'(1 + $urandom % 7);
      rs1 = 5'(1 + $urandom % 7);
      rs2 = 5'(1 + $urandom % 7);
      f3 = 3'($urandom % 8);
      // Forward target somewhere up to the final stores
      t = i + 1 + $urandom % (n - i);
      case (kind)
        0: prog.push_back(r_type((f3 == 0 || f3 == 5) && $urandom % 2 ? 7'h20 : 7'h00,
                                 rs2, rs1, f3, rd));
        1, 2: begin
          if (f3 == 3'd1 || f3 == 3'd5)
            prog.push_back(i_type({(f3 == 5 && $urandom % 2) ? 7'h20 : 7'h00,
                                   5'($urandom)}, rs1, f3, rd, 7'h13));
          else
            prog.push_back(i_type(12'($urandom), rs1, f3, rd, 7'h13));
        end
        3: prog.push_back({20'($urandom), rd, 7'h37});
        4: prog.push_back({20'($urandom), rd, 7'h17});
        5: prog.push_back(i_type(12'(4 * ($urandom % 64)), 5'd0, 3'd2, rd, 7'h03));
        6: prog.push_back(s_type(12'(4 * ($urandom % 64)), rs2, 5'd0));
        7: begin
          idx = $urandom % 6;
          prog.push_back(b_type(13'(4 * (t - i)), rs2, rs1, 3'(idx < 2 ? idx : idx + 2)));
        end
        8: prog.push_back(j_type(21'(4 * (t - i)), rd));
        default: begin
          tgt = reset_pc + 4 * t;
          prog.push_back(i_type(tgt[11:0], 5'd0, 3'd0, rd, 7'h67));
        end
      endcase
    end
    finish_program();
  endtask

  task automatic run_program(input string name);
    bit model_done;
    int cycles, common;
    @(posedge clk);
    #1 rst = 1'b1;
    for (int i = 0; i < 256; i++) imem[i] = nop_instr;
    for (int i = 0; i < prog.size(); i++) imem[64 + i] = prog[i];
    for (int i = 0; i < 64; i++) dmem[i] = data_fill(i);
    end_addr = reset_pc + 4 * (prog.size() - 1);
    run_model(model_done);
    if (!model_done) begin
      errors++;
      $display("%s: reference model did not reach the final loop", name);
    end
    repeat (16) @(posedge clk);
    obs_addr.delete();
    obs_data.delete();
    obs_loads = 0;
    end_hits = 0;
    #1 rst = 1'b0;
    @(negedge clk);
    if (instr_addr != reset_pc) begin
      errors++;
      $display("FAIL %s first fetch: expected %h, actual %h", name, reset_pc, instr_addr);
    end
    // The self-loop jal has executed once end_addr is fetched three times
    cycles = 0;
    while (end_hits < 3 && cycles < timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (end_hits < 3) begin
      errors++;
      $display("%s: core did not reach its final loop within %0d cycles", name, timeout);
    end
    if (obs_loads != exp_loads) begin
      errors++;
      $display("FAIL %s load count: expected %0d, actual %0d", name, exp_loads, obs_loads);
    end
    if (obs_addr.size() != exp_addr.size()) begin
      errors++;
      $display("%s: core made %0d stores but %0d were expected",
               name, obs_addr.size(), exp_addr.size());
    end
    common = obs_addr.size() < exp_addr.size() ? obs_addr.size() : exp_addr.size();
    for (int i = 0; i < common; i++) begin
      if (obs_addr[i] != exp_addr[i]) begin
        errors++;
        $display("FAIL %s store %0d address: expected %h, actual %h",
                 name, i, exp_addr[i], obs_addr[i]);
      end
      if (obs_data[i] != exp_data[i]) begin
        errors++;
        $display("FAIL %s store %0d data: expected %h, actual %h",
                 name, i, exp_data[i], obs_data[i]);
      end
    end
    stores_checked += common;
    programs++;
  endtask

  initial begin
    errors = 0;
    programs = 0;
    stores_checked = 0;
    obs_loads = 0;
    end_hits = 0;
    end_addr = '1;
    for (int i = 0; i < 256; i++) imem[i] = nop_instr;
    for (int i = 0; i < 64; i++) dmem[i] = data_fill(i);
    // Rising edge on rst clears the core before the first clock edge
    #1 rst = 1'b1;
    void'($urandom(32'h50e7));
    build_arith();
    run_program("arith");
    build_load_store();
    run_program("load_store");
    build_branch_jump();
    run_program("branch_jump");
    for (int p = 0; p < 20; p++) begin
      build_random();
      run_program($sformatf("random_%0d", p));
    end
    $display("Errors: %0d, programs: %0d, stores checked: %0d",
             errors, programs, stores_checked);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== verification/rv32i_core_sva.sv ====
`timescale 1ns/10ps

module rv32i_core_sva import rv32i_pkg::*; (
  input logic            clk,
  input logic            rst,
  input logic            data_we,
  input logic            data_re,
  input logic            redirect,
  input logic [xlen-1:0] redirect_target,
  input logic            de_valid,
  input logic [xlen-1:0] de_pc
);

  // A memory instruction either loads or stores
  assert property (@(posedge clk) disable iff (rst) !(data_we && data_re))
    else $error("data_we and data_re high together");

  assert property (@(posedge clk) rst |-> !data_we)
    else $error("data_we high during reset");

  // Two cycles after a redirect only the target path may be valid in execute
  assert property (@(posedge clk) disable iff (rst)
                   redirect |-> ##2 (!de_valid || de_pc == $past(redirect_target, 2)))
    else $error("valid instruction after redirect is not from the target path");

endmodule

bind rv32i_core rv32i_core_sva rv32i_core_sva_inst (
  .clk             (clk),
  .rst             (rst),
  .data_we         (data_we),
  .data_re         (data_re),
  .redirect        (redirect),
  .redirect_target (redirect_target),
  .de_valid        (de_valid),
  .de_pc           (de_pc)
);

// ==== hdl/rv32i_core.sv ====
`timescale 1ns/10ps

module rv32i_core import rv32i_pkg::*; #(
  parameter logic [xlen-1:0] RESET_PC = '0
) (
  input  logic            clk,
  input  logic            rst,
  output logic [xlen-1:0] instr_addr,
  input  logic [xlen-1:0] instr_rdata,
  output logic [xlen-1:0] data_addr,
  output logic [xlen-1:0] data_wdata,
  output logic            data_we,
  output logic            data_re,
  input  logic [xlen-1:0] data_rdata
);

  // Fetch
  logic [xlen-1:0] pc;
  logic [xlen-1:0] fetch_pc;

  // Fetch/decode register
  logic [xlen-1:0] fd_pc;
  logic [xlen-1:0] fd_instr;

  // Decode outputs
  control_t              ctrl_d;
  logic [reg_addr_w-1:0] rs1_d;
  logic [reg_addr_w-1:0] rs2_d;
  logic [reg_addr_w-1:0] rd_d;
  logic [xlen-1:0]       imm_d;
  logic [xlen-1:0]       rs1_val_d;
  logic [xlen-1:0]       rs2_val_d;

  // Decode/execute register
  logic                  de_valid;
  logic [xlen-1:0]       de_pc;
  control_t              de_ctrl;
  logic [xlen-1:0]       de_rs1_val;
  logic [xlen-1:0]       de_rs2_val;
  logic [xlen-1:0]       de_imm;
  logic [reg_addr_w-1:0] de_rd;

  // Execute results
  logic                  redirect;
  logic [xlen-1:0]       redirect_target;
  logic                  wb_we;
  logic [reg_addr_w-1:0] wb_addr;
  logic [xlen-1:0]       wb_data;

  // A taken transfer steers this cycle's fetch straight to the target
  assign fetch_pc   = redirect ? redirect_target : pc;
  assign instr_addr = fetch_pc;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc       <= RESET_PC;
      fd_instr <= nop_instr;
    end else begin
      pc       <= fetch_pc + xlen'(4);
      fd_instr <= instr_rdata;
    end
  end

  always_ff @(posedge clk) begin
    fd_pc <= fetch_pc;
  end

  decoder decoder_inst (
    .instr (fd_instr),
    .ctrl  (ctrl_d),
    .rs1   (rs1_d),
    .rs2   (rs2_d),
    .rd    (rd_d),
    .imm   (imm_d)
  );

  regfile regfile_inst (
    .clk    (clk),
    .rst    (rst),
    .we     (wb_we),
    .waddr  (wb_addr),
    .raddr1 (rs1_d),
    .raddr2 (rs2_d),
    .wdata  (wb_data),
    .rdata1 (rs1_val_d),
    .rdata2 (rs2_val_d)
  );

  // The instruction in decode is squashed on a redirect; the one behind it
  // was never fetched since fetch already moved to the target
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      de_valid <= 1'b0;
      de_ctrl  <= '0;
    end else begin
      de_valid <= !redirect;
      de_ctrl  <= ctrl_d;
    end
  end

  always_ff @(posedge clk) begin
    de_pc      <= fd_pc;
    de_rs1_val <= rs1_val_d;
    de_rs2_val <= rs2_val_d;
    de_imm     <= imm_d;
    de_rd      <= rd_d;
  end

  execute_stage execute_stage_inst (
    .valid           (de_valid),
    .pc              (de_pc),
    .ctrl            (de_ctrl),
    .rs1_val         (de_rs1_val),
    .rs2_val         (de_rs2_val),
    .imm             (de_imm),
    .rd              (de_rd),
    .data_rdata      (data_rdata),
    .data_addr       (data_addr),
    .data_wdata      (data_wdata),
    .data_we         (data_we),
    .data_re         (data_re),
    .redirect        (redirect),
    .redirect_target (redirect_target),
    .wb_we           (wb_we),
    .wb_addr         (wb_addr),
    .wb_data         (wb_data)
  );

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/10ps

module execute_stage import rv32i_pkg::*; (
  input  logic                  valid,
  input  logic [xlen-1:0]       pc,
  input  control_t              ctrl,
  input  logic [xlen-1:0]       rs1_val,
  input  logic [xlen-1:0]       rs2_val,
  input  logic [xlen-1:0]       imm,
  input  logic [reg_addr_w-1:0] rd,
  input  logic [xlen-1:0]       data_rdata,
  output logic [xlen-1:0]       data_addr,
  output logic [xlen-1:0]       data_wdata,
  output logic                  data_we,
  output logic                  data_re,
  output logic                  redirect,
  output logic [xlen-1:0]       redirect_target,
  output logic                  wb_we,
  output logic [reg_addr_w-1:0] wb_addr,
  output logic [xlen-1:0]       wb_data
);

  logic [xlen-1:0] op1;
  logic [xlen-1:0] op2;
  logic [xlen-1:0] alu_result;
  logic            branch_cond;

  always_comb begin
    case (ctrl.op1_sel)
      OP1_PC:   op1 = pc;
      OP1_ZERO: op1 = '0;
      default:  op1 = rs1_val;
    endcase
  end

  assign op2 = (ctrl.op2_sel == OP2_IMM) ? imm : rs2_val;

  alu alu_inst (
    .op     (ctrl.alu_op),
    .a      (op1),
    .b      (op2),
    .result (alu_result)
  );

  // Branch comparison on the register operands
  always_comb begin
    case (ctrl.branch_funct3)
      3'b000:  branch_cond = rs1_val == rs2_val;
      3'b001:  branch_cond = rs1_val != rs2_val;
      3'b100:  branch_cond = $signed(rs1_val) < $signed(rs2_val);
      3'b101:  branch_cond = $signed(rs1_val) >= $signed(rs2_val);
      3'b110:  branch_cond = rs1_val < rs2_val;
      3'b111:  branch_cond = rs1_val >= rs2_val;
      default: branch_cond = 1'b0;
    endcase
  end

  // Branches and JAL add pc + imm in the ALU, JALR adds rs1 + imm
  assign redirect        = valid && (ctrl.jump || (ctrl.branch && branch_cond));
  assign redirect_target = ctrl.is_jalr ? {alu_result[xlen-1:1], 1'b0} : alu_result;

  // Word-only data port, address is rs1 + imm from the ALU
  assign data_addr  = alu_result;
  assign data_wdata = rs2_val;
  assign data_we    = valid && ctrl.mem_write;
  assign data_re    = valid && ctrl.mem_read;

  assign wb_we   = valid && ctrl.reg_write;
  assign wb_addr = rd;

  always_comb begin
    case (ctrl.wb_sel)
      WB_MEM:  wb_data = data_rdata;
      WB_PC4:  wb_data = pc + xlen'(4);
      WB_IMM:  wb_data = imm;
      default: wb_data = alu_result;
    endcase
  end

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/10ps

module alu import rv32i_pkg::*; (
  input  alu_op_t         op,
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  output logic [xlen-1:0] result
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // Only the low five bits of b count for shifts
  assign shamt       = b[4:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_SLL:  result = a << shamt;
      ALU_SLT:  result = {{(xlen-1){1'b0}}, lt_signed};
      ALU_SLTU: result = {{(xlen-1){1'b0}}, lt_unsigned};
      ALU_XOR:  result = a ^ b;
      ALU_SRL:  result = a >> shamt;
      ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
      ALU_OR:   result = a | b;
      ALU_AND:  result = a & b;
      default:  result = a + b;
    endcase
  end

endmodule

// ==== hdl/regfile.sv ====
`timescale 1ns/10ps

module regfile import rv32i_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  we,
  input  logic [reg_addr_w-1:0] waddr,
  input  logic [reg_addr_w-1:0] raddr1,
  input  logic [reg_addr_w-1:0] raddr2,
  input  logic [xlen-1:0]       wdata,
  output logic [xlen-1:0]       rdata1,
  output logic [xlen-1:0]       rdata2
);

  // x0 has no storage
  logic [xlen-1:0] regs [1:31];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // Write-through: a write in execute is seen by decode in the same cycle
  assign rdata1 = (raddr1 == '0)                ? '0 :
                  (we && waddr == raddr1)       ? wdata : regs[raddr1];
  assign rdata2 = (raddr2 == '0)                ? '0 :
                  (we && waddr == raddr2)       ? wdata : regs[raddr2];

endmodule

// ==== hdl/decoder.sv ====
`timescale 1ns/10ps

module decoder import rv32i_pkg::*; (
  input  logic [xlen-1:0]       instr,
  output control_t              ctrl,
  output logic [reg_addr_w-1:0] rs1,
  output logic [reg_addr_w-1:0] rs2,
  output logic [reg_addr_w-1:0] rd,
  output logic [xlen-1:0]       imm
);

  opcode_t   opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  imm_type_t imm_type;

  // Map funct3 plus the alternate bit (instr[30]) onto an ALU operation
  function automatic alu_op_t alu_op_for(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign opcode = opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];

  // Anything not matched below leaves ctrl cleared, which behaves as a NOP
  always_comb begin
    ctrl     = '0;
    imm_type = IMM_I;
    case (opcode)
      OP: begin
        if (funct7 == 7'b0000000 ||
            (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          ctrl.reg_write = 1'b1;
          ctrl.alu_op    = alu_op_for(funct3, funct7[5]);
        end
      end
      OP_IMM: begin
        // Shift immediates carry a restricted funct7
        if ((funct3 != 3'b001 && funct3 != 3'b101) ||
            funct7 == 7'b0000000 ||
            (funct3 == 3'b101 && funct7 == 7'b0100000)) begin
          ctrl.reg_write = 1'b1;
          ctrl.op2_sel   = OP2_IMM;
          ctrl.alu_op    = alu_op_for(funct3, funct3 == 3'b101 && funct7[5]);
        end
      end
      LUI: begin
        imm_type       = IMM_U;
        ctrl.reg_write = 1'b1;
        ctrl.op1_sel   = OP1_ZERO;
        ctrl.op2_sel   = OP2_IMM;
        ctrl.wb_sel    = WB_IMM;
      end
      AUIPC: begin
        imm_type       = IMM_U;
        ctrl.reg_write = 1'b1;
        ctrl.op1_sel   = OP1_PC;
        ctrl.op2_sel   = OP2_IMM;
      end
      JAL: begin
        imm_type       = IMM_J;
        ctrl.reg_write = 1'b1;
        ctrl.jump      = 1'b1;
        ctrl.op1_sel   = OP1_PC;
        ctrl.op2_sel   = OP2_IMM;
        ctrl.wb_sel    = WB_PC4;
      end
      JALR: begin
        if (funct3 == 3'b000) begin
          ctrl.reg_write = 1'b1;
          ctrl.jump      = 1'b1;
          ctrl.is_jalr   = 1'b1;
          ctrl.op2_sel   = OP2_IMM;
          ctrl.wb_sel    = WB_PC4;
        end
      end
      BRANCH: begin
        // funct3 010 and 011 are reserved
        if (funct3 != 3'b010 && funct3 != 3'b011) begin
          imm_type           = IMM_B;
          ctrl.branch        = 1'b1;
          ctrl.branch_funct3 = funct3;
          ctrl.op1_sel       = OP1_PC;
          ctrl.op2_sel       = OP2_IMM;
        end
      end
      LOAD: begin
        if (funct3 == 3'b010) begin
          ctrl.reg_write = 1'b1;
          ctrl.mem_read  = 1'b1;
          ctrl.op2_sel   = OP2_IMM;
          ctrl.wb_sel    = WB_MEM;
        end
      end
      STORE: begin
        if (funct3 == 3'b010) begin
          imm_type       = IMM_S;
          ctrl.mem_write = 1'b1;
          ctrl.op2_sel   = OP2_IMM;
        end
      end
      default: ctrl = '0;
    endcase
  end

  // Sign-extended immediate for the selected format
  always_comb begin
    case (imm_type)
      IMM_I:   imm = {{20{instr[31]}}, instr[31:20]};
      IMM_S:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      IMM_B:   imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      IMM_U:   imm = {instr[31:12], 12'b0};
      IMM_J:   imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      default: imm = '0;
    endcase
  end

endmodule

// ==== hdl/rv32i_pkg.sv ====
package rv32i_pkg;

  // Datapath and register index widths
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  // addi x0, x0, 0
  localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;

  // Major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011
  } opcode_t;

  // ALU_ADD is zero so a cleared control word is a harmless add
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_t;

  typedef enum logic [1:0] {
    OP1_RS1  = 2'd0,
    OP1_PC   = 2'd1,
    OP1_ZERO = 2'd2
  } op1_sel_t;

  typedef enum logic {
    OP2_RS2 = 1'b0,
    OP2_IMM = 1'b1
  } op2_sel_t;

  // Writeback source
  typedef enum logic [1:0] {
    WB_ALU = 2'd0,
    WB_MEM = 2'd1,
    WB_PC4 = 2'd2,
    WB_IMM = 2'd3
  } wb_sel_t;

  // Immediate formats
  typedef enum logic [2:0] {
    IMM_I = 3'd0,
    IMM_S = 3'd1,
    IMM_B = 3'd2,
    IMM_U = 3'd3,
    IMM_J = 3'd4
  } imm_type_t;

  // Decoded control word carried from decode into execute
  typedef struct packed {
    alu_op_t    alu_op;
    op1_sel_t   op1_sel;
    op2_sel_t   op2_sel;
    wb_sel_t    wb_sel;
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    logic       branch;
    logic       jump;
    logic       is_jalr;
    logic [2:0] branch_funct3;
  } control_t;

endpackage
